//--- compile.f
+incdir+design
design/cpu_pkg.sv
design/cpu_sequencer.sv
design/cpu_program_counter.sv
design/cpu_alu.sv
design/cpu_regfile.sv
design/cpu_status.sv
design/cpu_top.sv
dv/cpu_tb.sv

//--- design/cpu_alu.sv
// CPU ALU, registered result with carry, overflow, zero and negative
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_alu (
	input  logic             clk,
	input  cpu_pkg::data_t   a,
	input  cpu_pkg::data_t   b,
	input  logic             b_zero,
	input  logic             c_in,
	input  cpu_pkg::alu_op_t op,
	output cpu_pkg::data_t   result,
	output logic             co,
	output logic             vo,
	output logic             zo,
	output logic             no
);

	cpu_pkg::data_t bi;		// Operand after implied zero
	cpu_pkg::data_t add_b;		// Adder B, inverted to subtract
	logic           add_c;		// Adder carry in
	cpu_pkg::data_t sum;
	logic           sum_c;
	logic           sum_v;
	cpu_pkg::data_t r;

	assign bi = b_zero ? '0 : b;

	always_comb begin
		case (op)
			cpu_pkg::ALU_SBC, cpu_pkg::ALU_CMP, cpu_pkg::ALU_DEC: add_b = ~bi;
			default: add_b = bi;
		endcase
		case (op)
			cpu_pkg::ALU_ADC, cpu_pkg::ALU_SBC: add_c = c_in;	// Carry set is no borrow
			cpu_pkg::ALU_CMP, cpu_pkg::ALU_INC: add_c = 1'b1;
			default: add_c = 1'b0;		// DEC adds all ones
		endcase
	end

	assign {sum_c, sum} = {1'b0, a} + {1'b0, add_b} + {{`CPU_DATA_WIDTH{1'b0}}, add_c};
	// Signed overflow when like signs give an unlike result
	assign sum_v = (a[`CPU_DATA_WIDTH-1] == add_b[`CPU_DATA_WIDTH-1]) &&
		(sum[`CPU_DATA_WIDTH-1] != a[`CPU_DATA_WIDTH-1]);

	always_comb begin
		case (op)
			cpu_pkg::ALU_AND:    r = a & bi;
			cpu_pkg::ALU_ORA:    r = a | bi;
			cpu_pkg::ALU_EOR:    r = a ^ bi;
			cpu_pkg::ALU_PASS_B: r = bi;
			cpu_pkg::ALU_PASS_A: r = a;
			default:             r = sum;
		endcase
	end

	// Flag class picks which of these get used
	always_ff @(posedge clk) begin
		result <= r;
		co     <= sum_c;
		vo     <= sum_v;
		zo     <= (r == '0);
		no     <= r[`CPU_DATA_WIDTH-1];
	end

endmodule

//--- design/cpu_config.svh
// CPU configuration, giving bus widths, the reset vector location and the zero page
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data bus and register width
`define CPU_DATA_WIDTH 8

// Address bus width
`define CPU_ADDR_WIDTH 16

// Vector low byte address, high byte follows
`define CPU_RESET_VECTOR 16'hFFFC

// High address byte for zero-page stores
`define CPU_ZERO_PAGE 8'h00

`endif

//--- design/cpu_pkg.sv
// CPU shared types for bus words, sequencer states and datapath control classes
`include "cpu_config.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_WIDTH-1:0] data_t;	// One data byte
	typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;	// One bus address

	typedef enum logic [5:0] {
		VEC0,		// Fetch vector low
		VEC1,		// Fetch vector high, latch low
		VEC2,		// Load PC, first opcode fetch
		DECODE,		// Opcode on din, retire previous result
		IMM,		// Immediate operand into ALU
		ZP0,		// Zero-page write
		FETCH,		// Opcode fetch after a store
		REG,		// Implied register operation
		JMP0,		// Fetch target low
		JMP1,		// Fetch target high, jump
		BRA0,		// Fetch offset, test condition
		BRA1		// Add offset to PC
	} state_t;

	typedef enum logic [3:0] {
		ALU_ADC,
		ALU_SBC,
		ALU_CMP,
		ALU_AND,
		ALU_ORA,
		ALU_EOR,
		ALU_PASS_B,	// Loads
		ALU_PASS_A,	// Transfers
		ALU_INC,
		ALU_DEC
	} alu_op_t;

	typedef enum logic [1:0] {
		REG_A,
		REG_X,
		REG_Y
	} reg_sel_t;

	typedef enum logic [2:0] {
		FLAG_NONE,
		FLAG_NZ,
		FLAG_NZC,
		FLAG_NZCV,
		FLAG_CLC,	// Carry cleared
		FLAG_SEC	// Carry set
	} flag_op_t;

	typedef enum logic [1:0] {
		AB_PC,
		AB_VECTOR_LO,
		AB_VECTOR_HI,
		AB_ZERO_PAGE
	} ab_sel_t;

endpackage

//--- design/cpu_program_counter.sv
// CPU program counter with operand-low latch, branch add and address bus mux
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_program_counter (
	input  logic             clk,
	input  logic             reset,
	input  cpu_pkg::data_t   din,
	input  cpu_pkg::ab_sel_t ab_sel,
	input  logic             pc_inc,
	input  logic             pc_load_abs,
	input  logic             lo_capture,
	input  logic             branch_take,
	output cpu_pkg::addr_t   ab
);

	cpu_pkg::addr_t pc;
	cpu_pkg::data_t lo;		// Vector low, JMP low or branch offset
	cpu_pkg::addr_t offset;		// Sign-extended branch offset
	cpu_pkg::addr_t pc_base;	// Address fetched this cycle

	assign offset = {{(`CPU_ADDR_WIDTH-`CPU_DATA_WIDTH){lo[`CPU_DATA_WIDTH-1]}}, lo};

	always_comb begin
		if (pc_load_abs)
			pc_base = {din, lo};	// High byte straight off the bus
		else if (branch_take)
			pc_base = pc + offset;
		else
			pc_base = pc;
	end

	always_ff @(posedge clk) begin
		if (lo_capture)
			lo <= din;
	end

	// PC always points past the byte on ab
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= '0;
		else if (pc_inc | pc_load_abs | branch_take)
			pc <= pc_base + cpu_pkg::addr_t'(pc_inc);
	end

	always_comb begin
		case (ab_sel)
			cpu_pkg::AB_VECTOR_LO: ab = `CPU_RESET_VECTOR;
			cpu_pkg::AB_VECTOR_HI: ab = cpu_pkg::addr_t'(`CPU_RESET_VECTOR + 1);
			cpu_pkg::AB_ZERO_PAGE: ab = {`CPU_ZERO_PAGE, din};
			default:               ab = pc_base;
		endcase
	end

endmodule

//--- design/cpu_regfile.sv
// CPU register file holding A, X and Y, one read port and one write port
`timescale 1ns/1ns

module cpu_regfile (
	input  logic              clk,
	input  cpu_pkg::reg_sel_t rd_sel,
	input  cpu_pkg::reg_sel_t wr_sel,
	input  logic              we,
	input  cpu_pkg::data_t    wdata,
	output cpu_pkg::data_t    rdata
);

	cpu_pkg::data_t regs [3];	// Indexed by A, X, Y

	// Also the write bus
	assign rdata = regs[rd_sel];

	always_ff @(posedge clk) begin
		if (we)
			regs[wr_sel] <= wdata;
	end

endmodule

//--- design/cpu_sequencer.sv
// CPU sequencer, with the microcode FSM and the opcode decoder behind every strobe
`timescale 1ns/1ns

module cpu_sequencer (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::data_t    din,
	input  logic              branch_true,
	output cpu_pkg::ab_sel_t  ab_sel,
	output logic              pc_inc,
	output logic              pc_load_abs,
	output logic              lo_capture,
	output logic              branch_take,
	output cpu_pkg::alu_op_t  alu_op,
	output logic              alu_b_zero,
	output cpu_pkg::reg_sel_t rd_sel,
	output cpu_pkg::reg_sel_t wr_sel,
	output logic              reg_we,
	output cpu_pkg::flag_op_t flag_op,
	output logic [2:0]        cond_code,
	output logic              we
);

	cpu_pkg::state_t   state;
	cpu_pkg::state_t   d_state;		// Path taken by the opcode on din
	cpu_pkg::alu_op_t  d_op;		// Decoded ALU operation
	cpu_pkg::reg_sel_t d_src;		// Decoded source register
	cpu_pkg::reg_sel_t d_dst;		// Decoded destination register
	logic              d_load;		// Opcode writes a register
	cpu_pkg::flag_op_t d_flag;		// Decoded flag class
	logic              load_pending;	// Result waiting for next DECODE
	cpu_pkg::flag_op_t flag_pending;	// Flag update waiting for next DECODE

	// Opcode decoder, only looked at in DECODE
	always_comb begin
		d_state = cpu_pkg::REG;		// Unknown opcodes act as NOP
		d_op    = cpu_pkg::ALU_PASS_A;
		d_src   = cpu_pkg::REG_A;
		d_dst   = cpu_pkg::REG_A;
		d_load  = 1'b0;
		d_flag  = cpu_pkg::FLAG_NONE;
		casez (din)
			8'hA9, 8'hA2, 8'hA0: begin	// LDA, LDX, LDY #
				d_state = cpu_pkg::IMM;
				d_op    = cpu_pkg::ALU_PASS_B;
				d_load  = 1'b1;
				d_flag  = cpu_pkg::FLAG_NZ;
				if (din == 8'hA2)
					d_dst = cpu_pkg::REG_X;
				else if (din == 8'hA0)
					d_dst = cpu_pkg::REG_Y;
			end
			8'h69, 8'hE9: begin		// ADC, SBC #
				d_state = cpu_pkg::IMM;
				d_op    = (din == 8'h69) ? cpu_pkg::ALU_ADC : cpu_pkg::ALU_SBC;
				d_load  = 1'b1;
				d_flag  = cpu_pkg::FLAG_NZCV;
			end
			8'h29, 8'h09, 8'h49: begin	// AND, ORA, EOR #
				d_state = cpu_pkg::IMM;
				d_load  = 1'b1;
				d_flag  = cpu_pkg::FLAG_NZ;
				if (din == 8'h29)
					d_op = cpu_pkg::ALU_AND;
				else if (din == 8'h09)
					d_op = cpu_pkg::ALU_ORA;
				else
					d_op = cpu_pkg::ALU_EOR;
			end
			8'hC9: begin			// CMP #, flags only
				d_state = cpu_pkg::IMM;
				d_op    = cpu_pkg::ALU_CMP;
				d_flag  = cpu_pkg::FLAG_NZC;
			end
			8'h85: d_state = cpu_pkg::ZP0;	// STA zp
			8'h86: begin			// STX zp
				d_state = cpu_pkg::ZP0;
				d_src   = cpu_pkg::REG_X;
			end
			8'h84: begin			// STY zp
				d_state = cpu_pkg::ZP0;
				d_src   = cpu_pkg::REG_Y;
			end
			8'hAA, 8'hA8, 8'h8A, 8'h98: begin	// TAX, TAY, TXA, TYA
				d_load = 1'b1;
				d_flag = cpu_pkg::FLAG_NZ;
				if (din == 8'hAA)
					d_dst = cpu_pkg::REG_X;
				else if (din == 8'hA8)
					d_dst = cpu_pkg::REG_Y;
				else if (din == 8'h8A)
					d_src = cpu_pkg::REG_X;
				else
					d_src = cpu_pkg::REG_Y;
			end
			8'hE8, 8'hCA: begin		// INX, DEX
				d_op   = (din == 8'hE8) ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
				d_src  = cpu_pkg::REG_X;
				d_dst  = cpu_pkg::REG_X;
				d_load = 1'b1;
				d_flag = cpu_pkg::FLAG_NZ;
			end
			8'hC8, 8'h88: begin		// INY, DEY
				d_op   = (din == 8'hC8) ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
				d_src  = cpu_pkg::REG_Y;
				d_dst  = cpu_pkg::REG_Y;
				d_load = 1'b1;
				d_flag = cpu_pkg::FLAG_NZ;
			end
			8'h18: d_flag = cpu_pkg::FLAG_CLC;
			8'h38: d_flag = cpu_pkg::FLAG_SEC;
			8'h4C: d_state = cpu_pkg::JMP0;	// JMP abs
			8'b???1_0000: d_state = cpu_pkg::BRA0;	// Bxx rel
			default: ;
		endcase
	end

	// Instruction controls, held until the next DECODE
	always_ff @(posedge clk) begin
		if (state == cpu_pkg::DECODE) begin
			alu_op    <= d_op;
			rd_sel    <= d_src;
			wr_sel    <= d_dst;
			cond_code <= din[7:5];	// Flag select and sense
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			load_pending <= 1'b0;
			flag_pending <= cpu_pkg::FLAG_NONE;
		end else if (state == cpu_pkg::DECODE) begin
			load_pending <= d_load;
			flag_pending <= d_flag;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= cpu_pkg::VEC0;
		end else begin
			case (state)
				cpu_pkg::VEC0:   state <= cpu_pkg::VEC1;
				cpu_pkg::VEC1:   state <= cpu_pkg::VEC2;
				cpu_pkg::VEC2:   state <= cpu_pkg::DECODE;
				cpu_pkg::DECODE: state <= d_state;
				cpu_pkg::ZP0:    state <= cpu_pkg::FETCH;
				cpu_pkg::JMP0:   state <= cpu_pkg::JMP1;
				cpu_pkg::BRA0:   state <= branch_true ? cpu_pkg::BRA1 : cpu_pkg::DECODE;
				cpu_pkg::IMM,
				cpu_pkg::FETCH,
				cpu_pkg::REG,
				cpu_pkg::JMP1,
				cpu_pkg::BRA1:   state <= cpu_pkg::DECODE;
				default:         state <= cpu_pkg::VEC0;
			endcase
		end
	end

	// Address and PC strobes per state
	always_comb begin
		ab_sel      = cpu_pkg::AB_PC;
		pc_inc      = 1'b0;
		pc_load_abs = 1'b0;
		lo_capture  = 1'b0;
		branch_take = 1'b0;
		case (state)
			cpu_pkg::VEC0: ab_sel = cpu_pkg::AB_VECTOR_LO;
			cpu_pkg::VEC1: begin
				ab_sel     = cpu_pkg::AB_VECTOR_HI;
				lo_capture = 1'b1;
			end
			cpu_pkg::VEC2, cpu_pkg::JMP1: begin	// Jump and fetch target opcode
				pc_load_abs = 1'b1;
				pc_inc      = 1'b1;
			end
			cpu_pkg::DECODE: pc_inc = (d_state != cpu_pkg::REG);	// Skip operand byte
			cpu_pkg::IMM, cpu_pkg::FETCH, cpu_pkg::REG: pc_inc = 1'b1;
			cpu_pkg::ZP0: ab_sel = cpu_pkg::AB_ZERO_PAGE;
			cpu_pkg::JMP0: lo_capture = 1'b1;
			cpu_pkg::BRA0: begin
				lo_capture = 1'b1;		// Offset
				pc_inc     = ~branch_true;	// Hold PC for the add
			end
			cpu_pkg::BRA1: begin
				branch_take = 1'b1;
				pc_inc      = 1'b1;
			end
			default: ;
		endcase
	end

	assign alu_b_zero = (state == cpu_pkg::REG);	// Implied ops have no operand
	assign we         = (state == cpu_pkg::ZP0);
	// Retire the previous instruction while this opcode decodes
	assign reg_we     = (state == cpu_pkg::DECODE) & load_pending;
	assign flag_op    = (state == cpu_pkg::DECODE) ? flag_pending : cpu_pkg::FLAG_NONE;

endmodule

//--- design/cpu_status.sv
// CPU status flags C, Z, N and V with branch condition evaluation
`timescale 1ns/1ns

module cpu_status (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::flag_op_t flag_op,
	input  logic              co,
	input  logic              vo,
	input  logic              zo,
	input  logic              no,
	input  logic [2:0]        cond_code,
	output logic              c,
	output logic              branch_true
);

	logic z;
	logic n;
	logic v;
	logic sel_flag;		// Flag named by the branch opcode

	// Updated only on the retire edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			c <= 1'b0;
			z <= 1'b0;
			n <= 1'b0;
			v <= 1'b0;
		end else begin
			case (flag_op)
				cpu_pkg::FLAG_NZ: begin
					z <= zo;
					n <= no;
				end
				cpu_pkg::FLAG_NZC: begin	// CMP
					z <= zo;
					n <= no;
					c <= co;
				end
				cpu_pkg::FLAG_NZCV: begin	// ADC, SBC
					z <= zo;
					n <= no;
					c <= co;
					v <= vo;
				end
				cpu_pkg::FLAG_CLC: c <= 1'b0;
				cpu_pkg::FLAG_SEC: c <= 1'b1;
				default: ;
			endcase
		end
	end

	// Opcode bits 7:6 choose N, V, C, Z
	always_comb begin
		case (cond_code[2:1])
			2'b00:   sel_flag = n;
			2'b01:   sel_flag = v;
			2'b10:   sel_flag = c;
			default: sel_flag = z;
		endcase
	end

	assign branch_true = (sel_flag == cond_code[0]);	// Bit 5 is the sense

endmodule

//--- design/cpu_top.sv
// CPU top level joining sequencer, program counter, ALU, registers and flags
`timescale 1ns/1ns

module cpu_top (
	input  logic           clk,
	input  logic           reset,
	input  cpu_pkg::data_t din,
	output cpu_pkg::addr_t ab,
	output cpu_pkg::data_t dout,
	output logic           we
);

	cpu_pkg::ab_sel_t  ab_sel;
	logic              pc_inc;
	logic              pc_load_abs;
	logic              lo_capture;
	logic              branch_take;
	cpu_pkg::alu_op_t  alu_op;
	logic              alu_b_zero;
	cpu_pkg::reg_sel_t rd_sel;
	cpu_pkg::reg_sel_t wr_sel;
	logic              reg_we;
	cpu_pkg::flag_op_t flag_op;
	logic [2:0]        cond_code;
	logic              branch_true;
	cpu_pkg::data_t    alu_result;	// Write-back data
	logic              alu_co;
	logic              alu_vo;
	logic              alu_zo;
	logic              alu_no;
	logic              flag_c;		// Carry into ALU

	cpu_sequencer u_sequencer (
		.clk         (clk),
		.reset       (reset),
		.din         (din),
		.branch_true (branch_true),
		.ab_sel      (ab_sel),
		.pc_inc      (pc_inc),
		.pc_load_abs (pc_load_abs),
		.lo_capture  (lo_capture),
		.branch_take (branch_take),
		.alu_op      (alu_op),
		.alu_b_zero  (alu_b_zero),
		.rd_sel      (rd_sel),
		.wr_sel      (wr_sel),
		.reg_we      (reg_we),
		.flag_op     (flag_op),
		.cond_code   (cond_code),
		.we          (we)
	);

	cpu_program_counter u_program_counter (
		.clk         (clk),
		.reset       (reset),
		.din         (din),
		.ab_sel      (ab_sel),
		.pc_inc      (pc_inc),
		.pc_load_abs (pc_load_abs),
		.lo_capture  (lo_capture),
		.branch_take (branch_take),
		.ab          (ab)
	);

	// Register read port feeds both the ALU and the write bus
	cpu_alu u_alu (
		.clk    (clk),
		.a      (dout),
		.b      (din),
		.b_zero (alu_b_zero),
		.c_in   (flag_c),
		.op     (alu_op),
		.result (alu_result),
		.co     (alu_co),
		.vo     (alu_vo),
		.zo     (alu_zo),
		.no     (alu_no)
	);

	cpu_regfile u_regfile (
		.clk    (clk),
		.rd_sel (rd_sel),
		.wr_sel (wr_sel),
		.we     (reg_we),
		.wdata  (alu_result),
		.rdata  (dout)
	);

	cpu_status u_status (
		.clk         (clk),
		.reset       (reset),
		.flag_op     (flag_op),
		.co          (alu_co),
		.vo          (alu_vo),
		.zo          (alu_zo),
		.no          (alu_no),
		.cond_code   (cond_code),
		.c           (flag_c),
		.branch_true (branch_true)
	);

endmodule

//--- dv/cpu_tb.sv
// CPU testbench running directed programs on the core through a synchronous memory model
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_tb;

	localparam int          CLK_PERIOD  = 40;
	localparam int          TEST_COUNT  = 6;
	localparam int          TEST_CYCLES = 2000;	// Marker wait limit per test
	localparam logic [15:0] PROG_BASE   = 16'h0200;
	localparam logic [7:0]  MARKER      = 8'hFF;	// Zero-page end-of-program store

	logic           clk;
	logic           reset = 1'b1;
	cpu_pkg::data_t din   = '0;
	cpu_pkg::addr_t ab;
	cpu_pkg::data_t dout;
	logic           we;

	cpu_pkg::data_t mem [0:(1 << `CPU_ADDR_WIDTH)-1];
	logic           written [0:255];	// Zero-page store seen since load
	cpu_pkg::data_t prog [$];		// Program under construction
	integer         seed = 32'h9ca5_f1e6;
	int             errors = 0;
	int             checks = 0;
	int             tests_run = 0;

	cpu_top UUT (
		.clk   (clk),
		.reset (reset),
		.din   (din),
		.ab    (ab),
		.dout  (dout),
		.we    (we)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// Synchronous memory with read data one cycle after the address
	always @(posedge clk) begin
		din <= mem[ab];			// Old byte on a write cycle
		if (we === 1'b1) begin
			mem[ab] = dout;
			if (ab[15:8] == `CPU_ZERO_PAGE)
				written[ab[7:0]] = 1'b1;
		end
	end

	initial begin
		#(TEST_COUNT * TEST_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

	function automatic cpu_pkg::data_t fill_byte(input cpu_pkg::addr_t addr);
		return addr[15:8] ^ addr[7:0] ^ 8'h5A;	// Both address bytes
	endfunction

	function cpu_pkg::data_t rand_byte();
		logic [31:0] r;
		r = $random(seed);
		rand_byte = r[7:0];
	endfunction

	// Address of the next program byte
	function cpu_pkg::addr_t here();
		here = PROG_BASE + cpu_pkg::addr_t'(prog.size());
	endfunction

	task emit(input cpu_pkg::data_t b);
		prog.push_back(b);
	endtask

	task emit_pair(input cpu_pkg::data_t op, input cpu_pkg::data_t arg);
		emit(op);
		emit(arg);
	endtask

	task jump(input cpu_pkg::addr_t target);
		emit(8'h4C);			// JMP abs
		emit(target[7:0]);
		emit(target[15:8]);
	endtask

	// Marker store and a spin in place
	task close_program();
		emit_pair(8'h85, MARKER);
		jump(here());
	endtask

	// Reload memory while reset is held and release it
	task start_program(input cpu_pkg::addr_t vec);
		int i;
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);			// we is low so the next edge writes nothing
		for (i = 0; i < (1 << `CPU_ADDR_WIDTH); i++)
			mem[i] = fill_byte(cpu_pkg::addr_t'(i));
		for (i = 0; i < prog.size(); i++)
			mem[cpu_pkg::addr_t'(vec + i)] = prog[i];
		mem[`CPU_RESET_VECTOR]     = vec[7:0];
		mem[`CPU_RESET_VECTOR + 1] = vec[15:8];
		for (i = 0; i < 256; i++)
			written[i] = 1'b0;
		@(posedge clk);
		@(posedge clk);
		reset <= 1'b0;			// Two cycles high
	endtask

	task wait_for_marker(output logic seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < TEST_CYCLES && !seen; n++) begin
			@(negedge clk);
			if (written[MARKER])
				seen = 1'b1;
		end
		if (!seen) begin
			$display("Marker store to 00FF never arrived within %0d cycles", TEST_CYCLES);
			errors++;
		end
	endtask

	task expect_value(input logic [15:0] got, input logic [15:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task expect_byte(input logic [7:0] zp, input cpu_pkg::data_t exp, input string what);
		if (!written[zp]) begin
			checks++;
			errors++;
			$display("No store reached zero page %02h for %s", zp, what);
		end else begin
			expect_value({8'h00, mem[{`CPU_ZERO_PAGE, zp}]}, {8'h00, exp}, what);
		end
	endtask

	task expect_no_store(input logic [7:0] zp, input string what);
		checks++;
		if (written[zp]) begin
			errors++;
			$display("A store reached zero page %02h although %s", zp, what);
		end
	endtask

	task report_test(input string name, input int start);
		tests_run++;
		if (errors == start)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - start);
	endtask

	task verify_reset_vector();
		int             start;
		int             i;
		cpu_pkg::addr_t vec;
		cpu_pkg::addr_t exp [3];
		start = errors;
		vec = {rand_byte(), rand_byte()};
		prog.delete();
		start_program(vec);
		exp[0] = `CPU_RESET_VECTOR;
		exp[1] = `CPU_RESET_VECTOR + 1;
		exp[2] = vec;			// First opcode fetch
		for (i = 0; i < 3; i++) begin
			@(negedge clk);
			expect_value(ab, exp[i], $sformatf("ab in cycle %0d after reset", i));
			expect_value({15'b0, we}, 16'h0000, $sformatf("we in cycle %0d", i));
		end
		report_test("reset_vector", start);
	endtask

	task loads_and_stores();
		int             start;
		logic           seen;
		cpu_pkg::data_t a;
		cpu_pkg::data_t x;
		cpu_pkg::data_t y;
		start = errors;
		a = rand_byte();
		x = rand_byte();
		y = rand_byte();
		prog.delete();
		emit_pair(8'hA9, a);		// LDA #
		emit_pair(8'hA2, x);		// LDX #
		emit_pair(8'hA0, y);		// LDY #
		emit_pair(8'h85, 8'h40);	// STA
		emit_pair(8'h86, 8'h41);	// STX
		emit_pair(8'h84, 8'h42);	// STY
		close_program();
		start_program(PROG_BASE);
		wait_for_marker(seen);
		if (seen) begin
			expect_byte(8'h40, a, "STA of LDA value");
			expect_byte(8'h41, x, "STX of LDX value");
			expect_byte(8'h42, y, "STY of LDY value");
		end
		report_test("loads_stores", start);
	endtask

	// 6502 binary results where carry set means no borrow
	function automatic cpu_pkg::data_t alu_expect(input int k, input cpu_pkg::data_t a,
		input cpu_pkg::data_t b, input logic c);
		case (k)
			0:       alu_expect = a + b + {7'b0, c};
			1:       alu_expect = a - b - {7'b0, ~c};
			2:       alu_expect = a & b;
			3:       alu_expect = a | b;
			default: alu_expect = a ^ b;
		endcase
	endfunction

	task alu_operations();
		int             start;
		int             i;
		int             k;
		logic           seen;
		cpu_pkg::data_t r;
		cpu_pkg::data_t a_op [10];
		cpu_pkg::data_t b_op [10];
		logic           c_op [10];
		cpu_pkg::data_t ops [5];
		start = errors;
		ops = '{8'h69, 8'hE9, 8'h29, 8'h09, 8'h49};	// ADC SBC AND ORA EOR
		prog.delete();
		for (i = 0; i < 10; i++) begin
			a_op[i] = rand_byte();
			b_op[i] = rand_byte();
			r = rand_byte();
			c_op[i] = r[0];
			for (k = 0; k < 5; k++) begin
				emit_pair(8'hA9, a_op[i]);
				if (k < 2)
					emit(c_op[i] ? 8'h38 : 8'h18);	// SEC or CLC
				emit_pair(ops[k], b_op[i]);
				emit_pair(8'h85, 8'h60 + 5*i + k);
			end
		end
		close_program();
		start_program(PROG_BASE);
		wait_for_marker(seen);
		if (seen) begin
			for (i = 0; i < 10; i++)
				for (k = 0; k < 5; k++)
					expect_byte(8'h60 + 5*i + k, alu_expect(k, a_op[i], b_op[i], c_op[i]),
						$sformatf("op %0d on %02h,%02h c=%0b", k, a_op[i], b_op[i], c_op[i]));
		end
		report_test("alu_operations", start);
	endtask

	task transfers_and_steps();
		int             start;
		int             i;
		logic           seen;
		cpu_pkg::data_t a;
		cpu_pkg::data_t x;
		cpu_pkg::data_t y;
		cpu_pkg::data_t exp [8];
		start = errors;
		a = rand_byte();
		prog.delete();
		emit_pair(8'hA9, a);
		x = a;
		exp[0] = x;		// TAX
		x = x + 8'd1;
		exp[1] = x;		// INX
		a = x;
		exp[2] = a;		// TXA
		y = a;
		exp[3] = y;		// TAY
		y = y - 8'd1;
		exp[4] = y;		// DEY
		y = y - 8'd1;
		exp[5] = y;		// DEY
		a = y;
		exp[6] = a;		// TYA
		x = x - 8'd1;
		exp[7] = x;		// DEX
		emit(8'hAA);
		emit_pair(8'h86, 8'h50);
		emit(8'hE8);
		emit_pair(8'h86, 8'h51);
		emit(8'h8A);
		emit_pair(8'h85, 8'h52);
		emit(8'hA8);
		emit_pair(8'h84, 8'h53);
		emit(8'h88);
		emit_pair(8'h84, 8'h54);
		emit(8'h88);
		emit_pair(8'h84, 8'h55);
		emit(8'h98);
		emit_pair(8'h85, 8'h56);
		emit(8'hCA);
		emit_pair(8'h86, 8'h57);
		close_program();
		start_program(PROG_BASE);
		wait_for_marker(seen);
		if (seen) begin
			for (i = 0; i < 8; i++)
				expect_byte(8'h50 + i, exp[i], $sformatf("step %0d result", i));
		end
		report_test("transfers_steps", start);
	endtask

	task flags_and_branches();
		int             start;
		int             i;
		int             sum_s;		// Signed sum for overflow
		logic           seen;
		logic           adc_path;	// V branches need ADC
		logic           n;
		logic           z;
		logic           c;
		logic           v;
		logic           f;
		logic [8:0]     res;
		cpu_pkg::data_t a;
		cpu_pkg::data_t b;
		cpu_pkg::data_t r;
		logic           taken [8];
		string          names [8];
		start = errors;
		names = '{"BPL", "BMI", "BVC", "BVS", "BCC", "BCS", "BNE", "BEQ"};
		prog.delete();
		for (i = 0; i < 8; i++) begin
			a = rand_byte();
			r = rand_byte();
			b = r[0] ? a : rand_byte();	// Equal operands half the time
			adc_path = (i[2:1] == 2'b01);
			emit_pair(8'hA9, a);
			if (adc_path) begin
				res = {1'b0, a} + {1'b0, b};
				c = res[8];
				sum_s = $signed(a) + $signed(b);
				v = (sum_s > 127) || (sum_s < -128);
				emit(8'h18);		// CLC
				emit_pair(8'h69, b);
			end else begin
				res = {1'b0, a} - {1'b0, b};
				c = (a >= b);		// No borrow
				v = 1'b0;
				emit_pair(8'hC9, b);	// CMP #
			end
			n = res[7];
			z = (res[7:0] == 8'h00);
			case (i[2:1])			// N, V, C, Z by opcode bits 7:6
				2'd0:    f = n;
				2'd1:    f = v;
				2'd2:    f = c;
				default: f = z;
			endcase
			taken[i] = (f == i[0]);		// Bit 5 is the sense
			emit_pair({i[2:0], 5'b10000}, 8'd7);	// Over the fall-through path
			emit_pair(8'hA9, 8'h11);
			emit_pair(8'h85, 8'h20 + i);
			jump(here() + 7);
			emit_pair(8'hA9, 8'h22);
			emit_pair(8'h85, 8'h20 + i);
		end
		close_program();
		start_program(PROG_BASE);
		wait_for_marker(seen);
		if (seen) begin
			for (i = 0; i < 8; i++)
				expect_byte(8'h20 + i, taken[i] ? 8'h22 : 8'h11,
					$sformatf("%s path marker", names[i]));
		end
		report_test("flags_branches", start);
	endtask

	task jump_absolute();
		int             start;
		logic           seen;
		cpu_pkg::data_t a;
		start = errors;
		a = rand_byte();
		prog.delete();
		emit_pair(8'hA9, a);
		jump(here() + 5);		// Past the next store
		emit_pair(8'h85, 8'h30);	// Never runs
		emit_pair(8'h85, 8'h31);
		close_program();
		start_program(PROG_BASE);
		wait_for_marker(seen);
		if (seen) begin
			expect_no_store(8'h30, "JMP should have skipped it");
			expect_byte(8'h31, a, "store at JMP target");
		end
		report_test("jump_absolute", start);
	endtask

	initial begin
		verify_reset_vector();
		loads_and_stores();
		alu_operations();
		transfers_and_steps();
		flags_and_branches();
		jump_absolute();
		$display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
